/* common/synth_pkg.sv */
package synth_pkg;

    // Widths with a meaning of their own
    typedef logic [7:0] sample_t;    // Audio sample, unsigned
    typedef logic [5:0] note_t;      // Codes 0..59, five octaves of twelve
    typedef logic [9:0] period_t;    // Step period in clocks
    typedef logic [1:0] wave_sel_t;  // Waveform code

    localparam wave_sel_t WAVE_TRI = 2'd0;
    localparam wave_sel_t WAVE_SAW = 2'd1;
    localparam wave_sel_t WAVE_SQR = 2'd2;

    // Configuration held by the command receiver
    typedef struct packed {
        wave_sel_t wave;  // Selected generator
        note_t     note;  // Raw note code as received
    } synth_cfg_t;

    // Serial receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,  // Line high, waiting for start
        RX_START = 2'd1,  // Start bit check at half a bit
        RX_DATA  = 2'd2,  // Eight data bits, LSB first
        RX_STOP  = 2'd3   // Stop bit check and decode
    } rx_state_t;

    localparam int CLKS_PER_BIT = 4;  // Kept short for simulation

    // Command bytes
    localparam logic [7:0] CMD_TRI = 8'h54;  // 'T'
    localparam logic [7:0] CMD_SAW = 8'h53;  // 'S'
    localparam logic [7:0] CMD_SQR = 8'h51;  // 'Q'

    localparam int    NOTES_PER_OCTAVE = 12;
    localparam int    NOTE_COUNT       = 60;
    localparam note_t NOTE_DEFAULT     = 6'd33;  // A, octave 2

    // Octave 0 periods, C up to B; halved once per octave
    localparam period_t NOTE_BASE_PERIOD [NOTES_PER_OCTAVE] = '{
        10'd256, 10'd242, 10'd228, 10'd215,
        10'd203, 10'd192, 10'd181, 10'd171,
        10'd161, 10'd152, 10'd144, 10'd136
    };

    localparam int I2S_WORD_BITS = 16;  // Sample sent twice per word

endpackage

/* uart_rx/uart_cmd_rx.sv */
`timescale 1ns/100ps

module uart_cmd_rx (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rx,   // Serial line, idles high
    output synth_pkg::synth_cfg_t cfg   // Wave and note for the synth core
);

    synth_pkg::rx_state_t                        state;
    logic [$clog2(synth_pkg::CLKS_PER_BIT)-1:0] clk_cnt;    // Clocks into current bit
    logic [3:0]                                  bit_idx;    // Reaches 8 on entry to stop
    logic [7:0]                                  shift_reg;  // Byte assembly, LSB first
    logic                                        bit_mid;    // Mid-bit sample point

    // A full bit after the previous sample point
    assign bit_mid = (clk_cnt == synth_pkg::CLKS_PER_BIT - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= synth_pkg::RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            cfg     <= '{wave: synth_pkg::WAVE_TRI, note: '0};  // Triangle, note 0
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                synth_pkg::RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx) begin
                        state <= synth_pkg::RX_START;  // Possible start edge
                    end
                end
                synth_pkg::RX_START: begin
                    if (clk_cnt == synth_pkg::CLKS_PER_BIT / 2 - 1) begin
                        clk_cnt <= '0;  // Realign to mid-bit
                        // Line back high means a glitch
                        state   <= rx ? synth_pkg::RX_IDLE : synth_pkg::RX_DATA;
                    end
                end
                synth_pkg::RX_DATA: begin
                    if (bit_mid) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 4'd7) begin
                            state <= synth_pkg::RX_STOP;  // Last data bit taken
                        end
                    end
                end
                synth_pkg::RX_STOP: begin
                    if (bit_mid) begin
                        state <= synth_pkg::RX_IDLE;
                        if (rx) begin  // Framing ok, else byte dropped
                            case (shift_reg)
                                synth_pkg::CMD_TRI: cfg.wave <= synth_pkg::WAVE_TRI;
                                synth_pkg::CMD_SAW: cfg.wave <= synth_pkg::WAVE_SAW;
                                synth_pkg::CMD_SQR: cfg.wave <= synth_pkg::WAVE_SQR;
                                default:            cfg.note <= shift_reg[5:0];  // Note code
                            endcase
                        end
                    end
                end
                default: begin
                    state <= synth_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // Data bits shift in from the top, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == synth_pkg::RX_DATA && bit_mid) begin
            shift_reg <= {rx, shift_reg[7:1]};
        end
    end

    // Index only counts data bits while in the data state
    a_bit_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        state == synth_pkg::RX_DATA |-> bit_idx < 4'd8);

    // Configuration moves only out of a completed frame
    a_cfg_after_stop: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(cfg) |-> $past(state) == synth_pkg::RX_STOP);

endmodule

/* osc/note_divider.sv */
`timescale 1ns/100ps

module note_divider (
    input  logic             clk,
    input  logic             rst_n,
    input  synth_pkg::note_t note,  // Code from the receiver
    output logic             step   // One clock every period
);

    synth_pkg::note_t   note_eff;  // Codes 60..63 folded to default
    synth_pkg::note_t   note_q;    // Last code, change detect
    logic [3:0]         semitone;  // 0..11
    logic [2:0]         octave;    // 0..4
    synth_pkg::period_t period;    // Clocks between steps
    synth_pkg::period_t cnt;       // Down counter to next step

    assign note_eff = (note >= synth_pkg::NOTE_COUNT) ? synth_pkg::NOTE_DEFAULT : note;
    assign semitone = 4'(note_eff % synth_pkg::NOTES_PER_OCTAVE);
    assign octave   = 3'(note_eff / synth_pkg::NOTES_PER_OCTAVE);
    // One octave up halves the period
    assign period   = synth_pkg::NOTE_BASE_PERIOD[semitone] >> octave;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            note_q <= '0;
            cnt    <= synth_pkg::NOTE_BASE_PERIOD[0] - 1'b1;  // Note 0 after reset
            step   <= 1'b0;
        end else begin
            note_q <= note;
            step   <= 1'b0;
            if (note != note_q) begin
                cnt <= period - 1'b1;  // Restart on a new note
            end else if (cnt == '0) begin
                cnt  <= period - 1'b1;
                step <= 1'b1;          // Expiry
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Shortest period over the table keeps the oscillator within one step per 8 clocks
    a_period_min: assert property (@(posedge clk) disable iff (!rst_n)
        period >= 10'd8);

endmodule

/* osc/wave_osc.sv */
`timescale 1ns/100ps

module wave_osc (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 step,    // Advance pulse from the divider
    input  synth_pkg::wave_sel_t wave,    // Generator choice
    output synth_pkg::sample_t   sample   // Registered output
);

    synth_pkg::sample_t saw_cnt;  // Phase ramp, wraps
    synth_pkg::sample_t tri_cnt;  // Bounces 0..255
    logic               tri_up;   // Triangle direction
    logic               sqr_hi;   // Square level

    // Generators move only on a step
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            saw_cnt <= '0;
            tri_cnt <= '0;
            tri_up  <= 1'b1;
            sqr_hi  <= 1'b0;
        end else if (step) begin
            saw_cnt <= saw_cnt + 1'b1;
            sqr_hi  <= ~sqr_hi;
            if (tri_up) begin
                if (tri_cnt == '1) begin
                    tri_up  <= 1'b0;              // Top reached, turn down
                    tri_cnt <= tri_cnt - 1'b1;
                end else begin
                    tri_cnt <= tri_cnt + 1'b1;
                end
            end else begin
                if (tri_cnt == '0) begin
                    tri_up  <= 1'b1;              // Bottom reached, turn up
                    tri_cnt <= tri_cnt + 1'b1;
                end else begin
                    tri_cnt <= tri_cnt - 1'b1;
                end
            end
        end
    end

    // Output mux, registered every clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample <= '0;
        end else begin
            case (wave)
                synth_pkg::WAVE_SAW: sample <= saw_cnt;
                synth_pkg::WAVE_SQR: sample <= {$bits(synth_pkg::sample_t){sqr_hi}};  // 00 or FF
                default:             sample <= tri_cnt;  // Triangle, also unused code 3
            endcase
        end
    end

    // No jump between the two ends across a step
    a_tri_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        $past(step) |->
            !(($past(tri_cnt) == 8'hFF && tri_cnt == 8'h00) ||
              ($past(tri_cnt) == 8'h00 && tri_cnt == 8'hFF)));

endmodule

/* i2s/i2s_tx.sv */
`timescale 1ns/100ps

module i2s_tx (
    input  logic               clk,
    input  logic               rst_n,
    input  synth_pkg::sample_t sample,  // Taken at word boundaries only
    output logic               sck,     // Bit clock, clk / 2
    output logic               ws,      // Word select, toggles per word
    output logic               sd       // Serial data, MSB first
);

    logic [$clog2(synth_pkg::I2S_WORD_BITS)-1:0] bit_cnt;    // Bit within word
    logic [synth_pkg::I2S_WORD_BITS-1:0]         shift_reg;  // Word being sent

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck     <= 1'b0;
            ws      <= 1'b0;
            sd      <= 1'b0;
            bit_cnt <= '1;  // First falling sck starts a word
        end else begin
            sck <= ~sck;
            if (sck) begin  // Falling sck, data changes here
                if (bit_cnt == synth_pkg::I2S_WORD_BITS - 1) begin
                    bit_cnt <= '0;
                    ws      <= ~ws;        // Aligned with the new MSB
                    sd      <= sample[$bits(synth_pkg::sample_t)-1];
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    sd      <= shift_reg[synth_pkg::I2S_WORD_BITS-2];
                end
            end
        end
    end

    // Sample replicated into both bytes at load, then shifted left
    always_ff @(posedge clk) begin
        if (sck) begin
            if (bit_cnt == synth_pkg::I2S_WORD_BITS - 1) begin
                shift_reg <= {sample, sample};
            end else begin
                shift_reg <= shift_reg << 1;
            end
        end
    end

    // Framing stays locked to the bit counter, new word opens with its own MSB
    a_ws_at_bit0: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(ws) |-> bit_cnt == '0 && sd == shift_reg[synth_pkg::I2S_WORD_BITS-1]);

endmodule

/* hdl/wave_synth_top.sv */
`timescale 1ns/100ps

module wave_synth_top (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,   // Command line
    output logic sck,  // I2S bit clock
    output logic ws,   // I2S word select
    output logic sd    // I2S data
);

    synth_pkg::synth_cfg_t cfg;     // Current wave and note
    logic                  step;    // Oscillator advance
    synth_pkg::sample_t    sample;  // Selected generator output

    uart_cmd_rx u_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .cfg   (cfg)
    );

    note_divider u_div (
        .clk   (clk),
        .rst_n (rst_n),
        .note  (cfg.note),
        .step  (step)
    );

    wave_osc u_osc (
        .clk    (clk),
        .rst_n  (rst_n),
        .step   (step),
        .wave   (cfg.wave),
        .sample (sample)
    );

    i2s_tx u_i2s (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (sample),
        .sck    (sck),
        .ws     (ws),
        .sd     (sd)
    );

endmodule

/* bench/tb_wave_synth.sv */
`timescale 1ns/100ps

module tb_wave_synth;

    localparam int WORD_CLKS  = 2 * synth_pkg::I2S_WORD_BITS;  // One I2S word in clocks
    localparam int TEST_WORDS = 12;                            // Samples compared per test

    logic clk;
    logic rst_n;
    logic rx;
    logic sck;
    logic ws;
    logic sd;

    // Vector table, one entry per test
    logic [7:0]           vec_cmd[$];     // Wave command byte
    logic [7:0]           vec_note[$];    // Note byte
    logic [7:0]           vec_bad[$];     // Sent with low stop bit, FF for none
    synth_pkg::wave_sel_t vec_wave[$];
    synth_pkg::period_t   vec_period[$];
    string                vec_name[$];

    // I2S capture
    logic [15:0] words[$];          // Completed words
    logic [15:0] word_sr;
    int          word_bits = 0;
    int          words_started = 0;
    logic        ws_seen = 1'b0;    // ws level of the word in progress

    int cycles = 0;
    int cycle_limit = 0;

    wave_synth_top DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .sck   (sck),
        .ws    (ws),
        .sd    (sd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // Run length guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, I2S words stopped arriving", cycles);
            fail_run();
        end
    end

    // sd is stable at rising sck; a ws change marks the MSB of a new word
    always @(posedge sck) begin
        if (rst_n) begin
            if (ws !== ws_seen) begin
                ws_seen       = ws;
                word_sr       = {15'b0, sd};
                word_bits     = 1;
                words_started = words_started + 1;
            end else if (word_bits > 0 && word_bits < synth_pkg::I2S_WORD_BITS) begin
                word_sr   = {word_sr[14:0], sd};
                word_bits = word_bits + 1;
                if (word_bits == synth_pkg::I2S_WORD_BITS) begin
                    words.push_back(word_sr);
                end
            end
        end
    end

    task automatic fail_run();
        $display("Regression failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_sample(input string name, input synth_pkg::sample_t exp,
                                input synth_pkg::sample_t act);
        if (act !== exp) begin
            $display("ERR %s expected %02h actual %02h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_wave(input string name, input synth_pkg::wave_sel_t exp,
                              input synth_pkg::wave_sel_t act);
        if (act !== exp) begin
            $display("ERR %s expected wave %0d actual wave %0d", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_period(input string name, input synth_pkg::period_t exp,
                                input synth_pkg::period_t act);
        if (act !== exp) begin
            $display("ERR %s expected period %0d actual period %0d", name, exp, act);
            fail_run();
        end
    endtask

    // Semitone base period halved per octave, codes past the table fold to A2
    function automatic synth_pkg::period_t note_period(input logic [7:0] note_byte);
        int code;
        code = int'(note_byte[5:0]);
        if (code >= synth_pkg::NOTE_COUNT) begin
            code = int'(synth_pkg::NOTE_DEFAULT);
        end
        return synth_pkg::NOTE_BASE_PERIOD[code % synth_pkg::NOTES_PER_OCTAVE]
               >> (code / synth_pkg::NOTES_PER_OCTAVE);
    endfunction

    // Square level after k toggles
    function automatic synth_pkg::sample_t square_after(input synth_pkg::sample_t s,
                                                         input int k);
        return (k % 2 != 0) ? ~s : s;
    endfunction

    task automatic load_vectors();
        int         fd;
        int         n;
        string      line;
        logic [7:0] cmd;
        logic [7:0] note;
        logic [7:0] bad;
        logic [7:0] wave;
        int         period;
        string      name;
        fd = $fopen("bench/wave_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open bench/wave_vectors.txt");
            fail_run();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != 8'h23) begin  // Skip blanks and # lines
                n = $sscanf(line, "%h %h %h %h %d %s", cmd, note, bad, wave, period, name);
                if (n != 6) begin
                    $display("Malformed vector line: %s", line);
                    fail_run();
                end
                vec_cmd.push_back(cmd);
                vec_note.push_back(note);
                vec_bad.push_back(bad);
                vec_wave.push_back(wave[1:0]);
                vec_period.push_back(period[9:0]);
                vec_name.push_back(name);
            end
        end
        $fclose(fd);
    endtask

    // One serial bit, CLKS_PER_BIT clocks long
    task automatic drive_bit(input logic level);
        @(posedge clk);
        #2;
        rx = level;
        repeat (synth_pkg::CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] data, input logic stop_bit);
        int i;
        drive_bit(1'b0);                 // Start
        for (i = 0; i < 8; i++) begin
            drive_bit(data[i]);          // LSB first
        end
        drive_bit(stop_bit);
        drive_bit(1'b1);                 // Idle gap
        drive_bit(1'b1);
    endtask

    task automatic wait_words(input int count);
        while (words.size() < count) begin
            @(posedge clk);
        end
    endtask

    task automatic run_test(input int idx);
        string              name;
        int                 first_idx;
        int                 f;
        int                 c;
        int                 lo;
        int                 hi;
        int                 i;
        int                 d_prev;
        int                 d_cur;
        synth_pkg::sample_t prev;
        synth_pkg::sample_t cur;
        synth_pkg::sample_t exp;
        name = vec_name[idx];
        check_period(name, note_period(vec_note[idx]), vec_period[idx]);
        send_byte(vec_cmd[idx], 1'b1);
        send_byte(vec_note[idx], 1'b1);
        if (vec_bad[idx] != 8'hFF) begin
            send_byte(vec_bad[idx], 1'b0);  // Framing error, must be ignored
        end
        repeat (4) @(posedge clk);
        check_wave(name, vec_wave[idx], DUT.cfg.wave);
        first_idx = words_started + 1;      // Skip the word around the change
        wait_words(first_idx + TEST_WORDS);
        f      = WORD_CLKS / int'(vec_period[idx]);  // Steps per word, low
        c      = (WORD_CLKS + int'(vec_period[idx]) - 1) / int'(vec_period[idx]);
        d_prev = 0;
        if (vec_wave[idx] == synth_pkg::WAVE_SQR) begin
            cur = words[first_idx][7:0];
            exp = (cur == 8'hFF) ? 8'hFF : 8'h00;
            check_sample(name, exp, cur);
        end
        for (i = first_idx + 1; i < first_idx + TEST_WORDS; i++) begin
            prev = words[i-1][7:0];
            cur  = words[i][7:0];
            case (vec_wave[idx])
                synth_pkg::WAVE_SAW: begin
                    exp = (8'(cur - prev) == 8'(c)) ? 8'(prev + c) : 8'(prev + f);
                    check_sample(name, exp, cur);
                end
                synth_pkg::WAVE_SQR: begin
                    exp = (cur == square_after(prev, c)) ? square_after(prev, c)
                                                         : square_after(prev, f);
                    check_sample(name, exp, cur);
                end
                default: begin
                    lo  = (int'(prev) > c) ? int'(prev) - c : 0;
                    hi  = (int'(prev) + c < 255) ? int'(prev) + c : 255;
                    exp = (int'(cur) < lo) ? 8'(lo) : ((int'(cur) > hi) ? 8'(hi) : cur);
                    check_sample(name, exp, cur);
                    d_cur = int'(cur) - int'(prev);
                    // Direction may only turn near an end
                    if (d_prev > 0 && d_cur < 0 && int'(prev) < 255 - c) begin
                        check_sample(name, 8'(255 - c), prev);
                    end
                    if (d_prev < 0 && d_cur > 0 && int'(prev) > c) begin
                        check_sample(name, 8'(c), prev);
                    end
                    if (d_cur != 0) begin
                        d_prev = d_cur;
                    end
                end
            endcase
        end
    endtask

    initial begin
        int t;
        int i;
        rx    = 1'b1;
        rst_n = 1'b0;
        load_vectors();
        cycle_limit = vec_name.size() * (20 * WORD_CLKS + 64) + 200;
        repeat (8) @(posedge clk);
        #2;
        check_level("reset_sck", 1'b0, sck);
        check_level("reset_ws", 1'b0, ws);
        check_level("reset_sd", 1'b0, sd);
        rst_n = 1'b1;
        wait_words(1);
        check_sample("reset_word_hi", 8'h00, words[0][15:8]);
        check_sample("reset_word_lo", 8'h00, words[0][7:0]);
        for (t = 0; t < vec_name.size(); t++) begin
            run_test(t);
        end
        for (i = 0; i < words.size(); i++) begin
            check_sample($sformatf("replication_%0d", i), words[i][15:8], words[i][7:0]);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

/* bench/wave_vectors.txt */
# cmd note bad wave period name
# hex bytes; bad is sent with a low stop bit, FF for none; wave 0 tri 1 saw 2 sqr; period decimal
51 3B FF 2 8 sqr_b_oct4
51 24 FF 2 32 sqr_c_oct3
51 2B FF 2 21 sqr_g_oct3
53 30 FF 1 16 saw_c_oct4
53 35 FF 1 12 saw_f_oct4
53 E4 FF 1 32 saw_masked_c_oct3
53 39 30 1 9 saw_bad_frame
54 3B FF 0 8 tri_b_oct4
54 2D FF 0 19 tri_a_oct3
54 26 FF 0 28 tri_d_oct3

/* compile.f */
common/synth_pkg.sv
uart_rx/uart_cmd_rx.sv
osc/note_divider.sv
osc/wave_osc.sv
i2s/i2s_tx.sv
hdl/wave_synth_top.sv
bench/tb_wave_synth.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       := tb_wave_synth
FILELIST  := compile.f
VECTORS   := bench/wave_vectors.txt
PASS_MSG  := Regression passed

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line appears in the output
run: $(SIM_BIN) $(VECTORS)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
